// ==== bench/tb_obj_engine.sv ====
`timescale 1ns/1ps
`include "obj_consts.svh"

module tb_obj_engine
    import obj_types_pkg::*;
    import video_types_pkg::*;
();

    localparam int LINE_CYCLES    = 1024;
    localparam int WINDOW         = 640;    // all drawing of a line is over by here
    localparam int N_LINES        = 50;
    localparam int TIMEOUT_CYCLES = N_LINES * LINE_CYCLES + 2000;

    logic                          clk       = 1'b0;
    logic                          rst       = 1'b1;
    logic                          pxl_cen   = 1'b0;
    logic                          hinit     = 1'b0;
    logic [7:0]                    vdump     = '0;
    hpos_t                         hdump     = '0;
    logic                          tbl_we    = 1'b0;
    logic [$clog2(`OBJ_COUNT)-1:0] tbl_addr  = '0;
    obj_attr_t                     tbl_data  = '0;
    logic                          prog_en   = 1'b0;
    pal_index_t                    prog_addr = '0;
    pixel_t                        prog_data = '0;
    rom_word_t                     rom_data  = '0;
    logic                          rom_ok    = 1'b0;
    logic                          rom_cs;
    rom_addr_t                     rom_addr;
    pixel_t                        pxl;

    // reference model state
    obj_attr_t tbl_m [`OBJ_COUNT];
    pixel_t    pal_m [256];
    rom_word_t rom_mem [1 << `ROM_AW];
    pixel_t    disp_line [256];     // half now on screen
    pixel_t    next_line [256];     // half being drawn
    int        hcnt      = 0;
    int        rom_wait  = 0;
    int        cycle_cnt = 0;
    int        n_checks  = 0;
    int        n_errors  = 0;
    logic      video_on  = 1'b0;

    always #20 clk = ~clk;

    obj_engine u_dut (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .hinit     (hinit),
        .vdump     (vdump),
        .hdump     (hdump),
        .tbl_we    (tbl_we),
        .tbl_addr  (tbl_addr),
        .tbl_data  (tbl_data),
        .prog_en   (prog_en),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .pxl       (pxl)
    );

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("run hung: still going after %0d cycles", cycle_cnt);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check_val(input logic [31:0] act, input logic [31:0] exp, input string what);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("error at time %0t: %s, got %0h, expected %0h", $time, what, act, exp);
        end
    endtask

    // expected pixels of one line, later entries painted over earlier ones
    task automatic render_line(input logic [7:0] line);
        obj_attr_t  e;
        logic [7:0] diff;
        logic [3:0] row;
        rom_word_t  w;
        pixel_t     v;
        hpos_t      pos;
        foreach (next_line[i])
            next_line[i] = '0;
        for (int i = 0; i < `OBJ_COUNT; i++) begin
            e    = tbl_m[i];
            diff = line - e.y;
            if (diff < `OBJ_SIZE) begin
                row = diff[3:0] ^ {4{e.vflip}};
                for (int p = 0; p < `OBJ_SIZE; p++) begin
                    w   = rom_mem[{e.code, row, p[3]}];     // left word holds pixels 0 to 7
                    v   = pal_m[{e.pal, w[4*(p%8) +: 4]}];
                    pos = e.hflip ? e.x + 8'd15 - 8'(p) : e.x + 8'(p);
                    if (v != '0)
                        next_line[pos] = v;
                end
            end
        end
    endtask

    // one clock, checks what the last edge produced, then drives the next cycle
    task automatic tick();
        @(posedge clk);
        #1;
        if (video_on && pxl_cen)
            check_val(pxl, disp_line[hdump], $sformatf("line %0d pixel %0d", vdump, hdump));
        if (video_on && hinit) begin
            disp_line = next_line;
            render_line(vdump + 8'd1);
        end
        tbl_we  = 1'b0;
        prog_en = 1'b0;
        // graphics ROM with random latency
        if (rom_ok) begin
            rom_ok = 1'b0;
        end else if (rom_cs) begin
            if (rom_wait == 0) begin
                rom_ok   = 1'b1;
                rom_data = rom_mem[rom_addr];
                rom_wait = $urandom_range(8, 0);
            end else begin
                rom_wait--;
            end
        end
        if (video_on) begin
            hcnt = (hcnt + 1) % LINE_CYCLES;
            if (hcnt == 0)
                vdump = vdump + 8'd1;
            hinit   = (hcnt == 0);
            pxl_cen = (hcnt % 4 == 0);
            hdump   = hpos_t'(hcnt / 4);
        end
    endtask

    task automatic place(input int i, input logic [7:0] top, input hpos_t left,
                         input logic [6:0] obj_code, input logic [3:0] obj_pal,
                         input logic hf, input logic vf);
        obj_attr_t a;
        a = '{y: top, x: left, code: obj_code, pal: obj_pal, hflip: hf, vflip: vf};
        tbl_we   = 1'b1;
        tbl_addr = i[3:0];
        tbl_data = a;
        tbl_m[i] = a;
        tick();
    endtask

    task automatic set_pal(input pal_index_t addr, input pixel_t val);
        prog_en     = 1'b1;
        prog_addr   = addr;
        prog_data   = val;
        pal_m[addr] = val;
        tick();
    endtask

    task automatic hide_all(input logic [7:0] rline);
        for (int i = 0; i < `OBJ_COUNT; i++)
            place(i, rline + 8'd100, 8'd0, 7'd0, 4'd0, 1'b0, 1'b0);  // parked far below
    endtask

    task automatic goto_window(output logic [7:0] rline);
        do
            tick();
        while (hcnt != WINDOW);
        rline = vdump + 8'd2;   // drawn after the next hinit
    endtask

    task automatic random_line(input logic [7:0] rline);
        for (int i = 0; i < `OBJ_COUNT; i++)
            place(i, rline - 8'($urandom_range(23, 0)), 8'($urandom), 7'($urandom),
                  4'($urandom), 1'($urandom), 1'($urandom));
        for (int k = 0; k < 16; k++)
            set_pal(8'($urandom), 4'($urandom));
        repeat (64)
            rom_mem[$urandom_range((1 << `ROM_AW) - 1, 0)] = $urandom;
    endtask

    initial begin
        logic [7:0] rline;
        void'($urandom(9813));
        foreach (rom_mem[i])
            rom_mem[i] = $urandom;
        foreach (next_line[i])
            next_line[i] = '0;
        disp_line = next_line;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        tick();
        check_val(rom_cs, 0, "rom_cs after reset");
        check_val(pxl, 0, "pxl after reset");
        hide_all(8'd0);
        for (int a = 0; a < 256; a++)
            set_pal(8'(a), 4'($urandom));
        video_on = 1'b1;
        hcnt     = LINE_CYCLES - 1;    // hinit on the next cycle

        goto_window(rline);
        place(0, rline - 8'd5, 8'd40, 7'($urandom), 4'($urandom), 1'b0, 1'b0);

        // flips, two of them wrapping past 255
        goto_window(rline);
        place(0, rline - 8'd3, 8'd250, 7'd11, 4'd2, 1'b1, 1'b0);
        place(1, rline - 8'd7, 8'd120, 7'd12, 4'd6, 1'b1, 1'b1);
        place(2, rline - 8'd12, 8'd245, 7'd13, 4'd9, 1'b0, 1'b1);

        // later entry wins, its transparent colours show the earlier one
        goto_window(rline);
        hide_all(rline);
        for (int c = 0; c < 16; c++)
            set_pal({4'd3, 4'(c)}, (c % 3 == 0) ? 4'd0 : 4'(c));
        place(0, rline, 8'd100, 7'd20, 4'd4, 1'b0, 1'b0);
        place(1, rline, 8'd108, 7'd21, 4'd3, 1'b0, 1'b0);

        goto_window(rline);
        hide_all(rline);        // blank line after a busy one

        repeat (40) begin
            goto_window(rline);
            random_line(rline);
        end

        goto_window(rline);
        hide_all(rline);
        repeat (2)
            goto_window(rline);

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== design/obj_draw.sv ====
`timescale 1ns/1ps

module obj_draw
    import obj_types_pkg::*;
    import video_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       draw,
    input  hpos_t      xpos,
    input  logic [3:0] ysub,
    input  logic [3:0] pal,
    input  logic       hflip,
    input  logic       vflip,
    input  logic [6:0] code,
    input  rom_word_t  rom_data,
    input  logic       rom_ok,
    input  pixel_t     pal_pxl,
    output logic       busy,
    output logic       rom_cs,
    output rom_addr_t  rom_addr,
    output pal_index_t pal_addr,
    output hpos_t      buf_addr,
    output logic       buf_we
);

    rom_word_t  sh;         // pixels still to go with the next one in the low nibble
    logic [2:0] cnt;
    logic [3:0] cur_pal;
    logic       cur_hflip;
    hpos_t      wr_a;
    logic       we_dly;     // pixel presented to the palette last cycle
    logic       start;
    logic       load;
    logic       shift;

    assign start    = draw && !busy;
    assign load     = busy && rom_cs && rom_ok;
    assign shift    = busy && !rom_cs;
    assign pal_addr = {cur_pal, sh[3:0]};
    assign buf_we   = we_dly;   // palette output is ready now

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            rom_cs   <= 1'b0;
            rom_addr <= '0;
            cnt      <= '0;
            we_dly   <= 1'b0;
        end else begin
            we_dly <= shift;
            if (start) begin
                busy     <= 1'b1;
                rom_cs   <= 1'b1;
                rom_addr <= {code, ysub ^ {4{vflip}}, 1'b0};
            end
            if (load) begin
                rom_cs <= 1'b0;
                cnt    <= 3'd7;
            end
            if (shift) begin
                cnt <= cnt - 3'd1;
                if (cnt == 3'd0) begin
                    if (rom_addr.half) begin
                        busy <= 1'b0;       // row done
                    end else begin
                        rom_addr.half <= 1'b1;  // right half next
                        rom_cs        <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cur_pal   <= pal;
            cur_hflip <= hflip;
            wr_a      <= hflip ? xpos + 8'd15 : xpos;
        end
        if (load)
            sh <= rom_data;
        if (shift) begin
            sh   <= sh >> 4;
            wr_a <= cur_hflip ? wr_a - 8'd1 : wr_a + 8'd1;  // wraps past 255
        end
        buf_addr <= wr_a;   // lines up with the palette read latency
    end

    a_rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else $error("rom request changed before rom_ok");

    a_we_idle: assert property (@(posedge clk) disable iff (rst)
        !busy && !$past(busy) |-> !buf_we)
        else $error("buffer write while drawer idle");

endmodule

// ==== design/obj_engine.sv ====
`timescale 1ns/1ps
`include "obj_consts.svh"

module obj_engine
    import obj_types_pkg::*;
    import video_types_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pxl_cen,
    input  logic                          hinit,
    input  logic [7:0]                    vdump,
    input  hpos_t                         hdump,
    input  logic                          tbl_we,
    input  logic [$clog2(`OBJ_COUNT)-1:0] tbl_addr,
    input  obj_attr_t                     tbl_data,
    input  logic                          prog_en,
    input  pal_index_t                    prog_addr,
    input  pixel_t                        prog_data,
    input  rom_word_t                     rom_data,
    input  logic                          rom_ok,
    output logic                          rom_cs,
    output rom_addr_t                     rom_addr,
    output pixel_t                        pxl
);

    logic       draw;
    logic       busy;
    hpos_t      xpos;
    logic [3:0] ysub;
    logic [3:0] pal;
    logic       hflip;
    logic       vflip;
    logic [6:0] code;
    pal_index_t pal_addr;
    pixel_t     pal_pxl;
    hpos_t      buf_addr;
    logic       buf_we;

    if ($bits(rom_addr_t) != `ROM_AW || $bits(rom_word_t) != `ROM_DW) begin : g_rom_check
        $error("graphics ROM types do not match ROM_AW and ROM_DW");
    end

    obj_scan u_scan (
        .clk      (clk),
        .rst      (rst),
        .hinit    (hinit),
        .vdump    (vdump),
        .tbl_we   (tbl_we),
        .tbl_addr (tbl_addr),
        .tbl_data (tbl_data),
        .busy     (busy),
        .draw     (draw),
        .xpos     (xpos),
        .ysub     (ysub),
        .pal      (pal),
        .hflip    (hflip),
        .vflip    (vflip),
        .code     (code)
    );

    obj_draw u_draw (
        .clk      (clk),
        .rst      (rst),
        .draw     (draw),
        .xpos     (xpos),
        .ysub     (ysub),
        .pal      (pal),
        .hflip    (hflip),
        .vflip    (vflip),
        .code     (code),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .pal_pxl  (pal_pxl),
        .busy     (busy),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .pal_addr (pal_addr),
        .buf_addr (buf_addr),
        .buf_we   (buf_we)
    );

    obj_palette u_palette (
        .clk       (clk),
        .prog_en   (prog_en),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .rd_addr   (pal_addr),
        .q         (pal_pxl)
    );

    obj_line_buffer u_buffer (
        .clk     (clk),
        .rst     (rst),
        .swap    (hinit),       // halves change at line start
        .wr_addr (buf_addr),
        .wr_data (pal_pxl),
        .we      (buf_we),
        .rd_addr (hdump),
        .rd      (pxl_cen),
        .rd_data (pxl)
    );

endmodule

// ==== design/obj_line_buffer.sv ====
`timescale 1ns/1ps

module obj_line_buffer
    import video_types_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   swap,
    input  hpos_t  wr_addr,
    input  pixel_t wr_data,
    input  logic   we,
    input  hpos_t  rd_addr,
    input  logic   rd,
    output pixel_t rd_data
);

    // both halves in one array, upper address bit picks the half
    pixel_t mem [512];
    logic   sel;        // half now displayed
    logic   wr_en;

    assign wr_en = we && (wr_data != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            sel <= 1'b0;
        else if (swap)
            sel <= ~sel;
    end

    // starts blank, read-erase keeps every displayed half blank afterwards
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 512; i++)
                mem[i] <= '0;
        end else begin
            if (wr_en)
                mem[{~sel, wr_addr}] <= wr_data;    // hidden half
            if (rd)
                mem[{sel, rd_addr}] <= '0;          // erase behind the beam
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            rd_data <= '0;
        else if (rd)
            rd_data <= mem[{sel, rd_addr}];
    end

    // a swap without a read would leave one location of the old half unerased
    a_swap_rd: assert property (@(posedge clk) disable iff (rst) swap |-> rd)
        else $error("buffer swap without pixel read");

endmodule

// ==== design/obj_palette.sv ====
`timescale 1ns/1ps

module obj_palette
    import video_types_pkg::*;
(
    input  logic       clk,
    input  logic       prog_en,
    input  pal_index_t prog_addr,
    input  pixel_t     prog_data,
    input  pal_index_t rd_addr,
    output pixel_t     q
);

    pixel_t mem [256];  // loaded by the host before use

    always_ff @(posedge clk) begin
        if (prog_en)
            mem[prog_addr] <= prog_data;
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        q <= mem[rd_addr];
    end

endmodule

// ==== design/obj_scan.sv ====
`timescale 1ns/1ps
`include "obj_consts.svh"

module obj_scan
    import obj_types_pkg::*;
    import video_types_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             hinit,
    input  logic [7:0]                       vdump,
    input  logic                             tbl_we,
    input  logic [$clog2(`OBJ_COUNT)-1:0]    tbl_addr,
    input  obj_attr_t                        tbl_data,
    input  logic                             busy,
    output logic                             draw,
    output hpos_t                            xpos,
    output logic [3:0]                       ysub,
    output logic [3:0]                       pal,
    output logic                             hflip,
    output logic                             vflip,
    output logic [6:0]                       code
);

    localparam int IW = $clog2(`OBJ_COUNT);

    obj_attr_t   tbl [`OBJ_COUNT];
    logic [IW-1:0] idx;
    logic [7:0]  line;      // line being prepared
    logic        scanning;
    obj_attr_t   cur;
    logic [7:0]  diff;
    logic        hit;
    logic        test_en;

    assign cur     = tbl[idx];
    assign diff    = line - cur.y;          // wraps, so objects above the line fail
    assign hit     = diff < `OBJ_SIZE;
    // one entry per cycle, only while the drawer is free
    assign test_en = scanning && !busy && !draw && !hinit;

    always_ff @(posedge clk) begin
        if (tbl_we)
            tbl[tbl_addr] <= tbl_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scanning <= 1'b0;
            idx      <= '0;
            line     <= '0;
            draw     <= 1'b0;
        end else begin
            draw <= 1'b0;
            if (hinit) begin
                scanning <= 1'b1;
                idx      <= '0;
                line     <= vdump + 8'd1;
            end else if (test_en) begin
                draw <= hit;
                if (idx == IW'(`OBJ_COUNT - 1))
                    scanning <= 1'b0;   // wait for the next hinit
                else
                    idx <= idx + 1'b1;
            end
        end
    end

    // fields only matter alongside draw
    always_ff @(posedge clk) begin
        if (test_en) begin
            xpos  <= cur.x;
            ysub  <= diff[3:0];
            pal   <= cur.pal;
            hflip <= cur.hflip;
            vflip <= cur.vflip;
            code  <= cur.code;
        end
    end

    // the drawer would drop a request made while it is busy
    a_draw_idle: assert property (@(posedge clk) disable iff (rst) !(draw && busy))
        else $error("draw raised while drawer busy");

endmodule

// ==== design/obj_types_pkg.sv ====
package obj_types_pkg;

    // one entry of the object attribute table
    typedef struct packed {
        logic [7:0] y;      // top line
        logic [7:0] x;      // left pixel
        logic [6:0] code;
        logic [3:0] pal;
        logic       hflip;
        logic       vflip;
    } obj_attr_t;

    // graphics ROM word address
    typedef struct packed {
        logic [6:0] code;
        logic [3:0] row;
        logic       half;   // 0 = left eight pixels
    } rom_addr_t;

    // eight packed pixels
    typedef logic [31:0] rom_word_t;

endpackage

// ==== design/video_types_pkg.sv ====
package video_types_pkg;

    // 0 is transparent
    typedef logic [3:0] pixel_t;

    // palette PROM address, pal in the upper nibble and colour below
    typedef logic [7:0] pal_index_t;

    typedef logic [7:0] hpos_t;

endpackage

// ==== include/obj_consts.svh ====
`ifndef OBJ_CONSTS_SVH
`define OBJ_CONSTS_SVH

// object attribute table entries
`define OBJ_COUNT 16

// objects are square, this many pixels a side
`define OBJ_SIZE 16

// graphics ROM word address width (code, row, half)
`define ROM_AW 12

// graphics ROM word width, eight packed 4-bit pixels, lowest nibble first
`define ROM_DW 32

`endif

// ==== tb.f ====
+incdir+include
design/obj_types_pkg.sv
design/video_types_pkg.sv
design/obj_scan.sv
design/obj_draw.sv
design/obj_palette.sv
design/obj_line_buffer.sv
design/obj_engine.sv
bench/tb_obj_engine.sv
